// ==== bench/reg_display_assert.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent assertions on the pixel write port, bound to the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module reg_display_assert
    import text_display_pkg::*;
(
    input logic                   clock,
    input logic                   resetn,
    input logic [x_width-1:0]     pixel_x,
    input logic [y_width-1:0]     pixel_y,
    input logic [color_width-1:0] pixel_color,
    input logic                   plot
);

    // One write per cycle once out of reset
    plot_held: assert property (@(posedge clock) disable iff (!resetn) !$fell(plot))
        else $error("plot dropped while out of reset");

    on_screen: assert property (@(posedge clock) pixel_x < 10'd640 && pixel_y < 9'd480)
        else $error("pixel position outside the 640x480 screen");

    two_colors: assert property (@(posedge clock)
        pixel_color == color_on || pixel_color == color_off)
        else $error("pixel colour is neither foreground nor background");

endmodule

bind reg_display_top reg_display_assert u_assert (
    .clock       (clock),
    .resetn      (resetn),
    .pixel_x     (pixel_x),
    .pixel_y     (pixel_y),
    .pixel_color (pixel_color),
    .plot        (plot)
);

`default_nettype wire

// ==== bench/reg_display_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register text overlay testbench with clock, reset and LCG register
// stimulus, pixel reference model, output checks and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module reg_display_tb
    import text_display_pkg::*;
();

    localparam int num_regs        = 8;
    localparam int clock_period    = 8;
    localparam int reset_cycles    = 5;
    localparam int text_x0         = 10;
    localparam int title_y0        = 10;
    localparam int regs_y0         = 25;
    localparam int row_pitch       = 15;
    localparam int title_cycles    = 1088;
    localparam int frame_cycles    = 6144;
    localparam int watchdog_cycles = reset_cycles + title_cycles + 3 * frame_cycles + 200;

    localparam logic [8*title_len-1:0] title_chars = "GENERAL REGISTERS";

    logic                               clock;
    logic                               resetn;
    logic [num_regs-1:0][reg_width-1:0] reg_words;
    logic [x_width-1:0]                 pixel_x;
    logic [y_width-1:0]                 pixel_y;
    logic [color_width-1:0]             pixel_color;
    logic                               plot;

    // Model of the scan position the DUT counter holds
    draw_phase_t m_phase;
    int          m_gcol;
    int          m_grow;
    int          m_ccol;
    int          m_crow;
    int          titles_done;
    int          frames_done;
    logic [31:0] rng_state;

    reg_display_top dut (
        .clock       (clock),
        .resetn      (resetn),
        .reg_words   (reg_words),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_color (pixel_color),
        .plot        (plot)
    );

    always #(clock_period / 2) clock = ~clock;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // ASCII character to font index
    function automatic glyph_code_t char_code(input logic [7:0] ch);
        if (ch >= "0" && ch <= "9") begin
            return 6'(ch - "0");
        end else if (ch >= "A" && ch <= "F") begin
            return 6'(ch - "A" + 8'd10);
        end
        case (ch)
            "G":     return code_g;
            "I":     return code_i;
            "L":     return code_l;
            "N":     return code_n;
            "R":     return code_r;
            "S":     return code_s;
            "T":     return code_t;
            ":":     return code_colon;
            default: return code_space;
        endcase
    endfunction

    function automatic logic [7:0] hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return "0" + {4'd0, nib};
        end
        return "A" + {4'd0, nib} - 8'd10;
    endfunction

    // Character shown in one cell of the title or of a register line
    function automatic logic [7:0] cell_char(input draw_phase_t ph, input int col, input int row,
                                             input logic [reg_width-1:0] word);
        logic [8*title_len-1:0] shifted;
        logic [reg_width-1:0]   digits;
        shifted = title_chars >> (8 * (title_len - 1 - col));
        digits  = word >> (4 * (reg_line_len - 1 - col));  // Leftmost digit is the top nibble
        if (ph == phase_title) begin
            return shifted[7:0];
        end
        case (col)
            0:       return "R";
            1:       return "0" + 8'(row);
            2:       return ":";
            3:       return " ";
            default: return hex_char(digits[3:0]);
        endcase
    endfunction

    task automatic value_error(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("error: %s expected %h got %h", name, expected, actual);
        $display("Regression failed");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic check_outputs();
        logic [x_width-1:0]     exp_x;
        logic [y_width-1:0]     exp_y;
        logic [color_width-1:0] exp_color;
        logic                   exp_plot;
        logic [7:0]             bits;
        if (!resetn) begin
            exp_x     = '0;  // Everything cleared in reset
            exp_y     = '0;
            exp_color = color_off;
            exp_plot  = 1'b0;
        end else begin
            bits  = glyph_row_bits(char_code(cell_char(m_phase, m_ccol, m_crow,
                                   reg_words[3'(m_crow)])), 3'(m_grow));
            exp_x = x_width'(text_x0 + m_ccol * cell_pitch + m_gcol);
            if (m_phase == phase_title) begin
                exp_y = y_width'(title_y0 + m_grow);
            end else begin
                exp_y = y_width'(regs_y0 + m_crow * row_pitch + m_grow);
            end
            exp_color = bits[3'(7 - m_gcol)] ? color_on : color_off;
            exp_plot  = 1'b1;
        end
        assert (plot === exp_plot) else value_error("plot", 32'(exp_plot), 32'(plot));
        assert (pixel_x === exp_x) else value_error("pixel_x", 32'(exp_x), 32'(pixel_x));
        assert (pixel_y === exp_y) else value_error("pixel_y", 32'(exp_y), 32'(pixel_y));
        assert (pixel_color === exp_color)
            else value_error("pixel_color", 32'(exp_color), 32'(pixel_color));
    endtask

    task automatic reset_model();
        m_phase = phase_title;
        m_gcol  = 0;
        m_grow  = 0;
        m_ccol  = 0;
        m_crow  = 0;
    endtask

    task automatic advance_model();
        int last_col;
        int last_row;
        last_col = (m_phase == phase_title) ? title_len - 1 : reg_line_len - 1;
        last_row = (m_phase == phase_title) ? 0 : num_regs - 1;
        if (m_gcol < glyph_size - 1) begin
            m_gcol = m_gcol + 1;
        end else begin
            m_gcol = 0;
            if (m_grow < glyph_size - 1) begin
                m_grow = m_grow + 1;
            end else begin
                m_grow = 0;
                if (m_ccol < last_col) begin
                    m_ccol = m_ccol + 1;
                end else begin
                    m_ccol = 0;
                    if (m_crow < last_row) begin
                        m_crow = m_crow + 1;
                    end else begin
                        m_crow = 0;  // End of phase
                        if (m_phase == phase_title) begin
                            titles_done = titles_done + 1;
                        end else begin
                            frames_done = frames_done + 1;
                        end
                        m_phase = phase_regs;
                    end
                end
            end
        end
    endtask

    task automatic drive_inputs(input logic next_resetn);
        logic [31:0] pick;
        logic [31:0] word;
        int          idx;
        resetn    = next_resetn;
        rng_state = lcg_next(rng_state);
        if (rng_state[31:26] == 6'd0) begin  // About one edge in 64
            rng_state = lcg_next(rng_state);
            pick      = rng_state;
            rng_state = lcg_next(rng_state);
            word      = rng_state;
            // Registers 0 and 1 hold all hex digits until the first frame shows them
            if (frames_done == 0) begin
                idx = 2 + int'(pick[31:16] % 16'd6);
            end else begin
                idx = int'(pick[31:29]);
            end
            reg_words[3'(idx)] = word;
        end
    endtask

    task automatic step(input logic next_resetn);
        @(negedge clock);
        check_outputs();
        if (!resetn) begin
            reset_model();
        end else begin
            advance_model();
        end
        drive_inputs(next_resetn);
    endtask

    initial begin
        clock       = 1'b0;
        resetn      = 1'b0;
        rng_state   = 32'd24869;
        titles_done = 0;
        frames_done = 0;
        for (int i = 0; i < num_regs; i++) begin
            rng_state          = lcg_next(rng_state);
            reg_words[3'(i)] = rng_state;
        end
        reg_words[0] = 32'h0123_4567;
        reg_words[1] = 32'h89AB_CDEF;
        reset_model();

        repeat (reset_cycles - 1) step(1'b0);
        step(1'b1);

        // Title, first frame, then halfway into the second frame
        while (!(frames_done == 1 && m_crow == 3)) step(1'b1);
        repeat (3) step(1'b0);
        step(1'b1);

        while (titles_done < 2) step(1'b1);  // Restarted title
        repeat (16) step(1'b1);

        $display("Regression passed");
        $finish;
    end

    initial begin
        #(watchdog_cycles * clock_period);
        $display("Timeout: the drawing sequence did not complete, the run hung");
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== logic/draw_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Draw sequencer FSM: title once, then register frames forever
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module draw_sequencer
    import text_display_pkg::*;
(
    input  logic                  clock,
    input  logic                  resetn,
    glyph_scan_if.sequencer       scan
);

    draw_phase_t state;
    draw_phase_t next_state;

    always_comb begin
        next_state = state;
        case (state)
            phase_title: begin
                if (scan.scan_end) begin
                    next_state = phase_regs;  // Title drawn exactly once
                end
            end
            phase_regs: begin
                next_state = phase_regs;      // Frames follow back to back
            end
            default: begin
                next_state = phase_title;
            end
        endcase
    end

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            state <= phase_title;
        end else begin
            state <= next_state;
        end
    end

    assign scan.phase = state;

endmodule

`default_nettype wire

// ==== logic/glyph_scan_counter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Nested pixel, glyph row, cell and line counter
// with combinational end of phase decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module glyph_scan_counter
    import text_display_pkg::*;
#(
    parameter int num_regs = 8
) (
    input  logic                  clock,
    input  logic                  resetn,
    glyph_scan_if.counter         scan
);

    localparam logic [2:0] glyph_last = 3'(glyph_size - 1);

    logic [4:0] col_last;
    logic [2:0] row_last;
    logic       glyph_done;
    logic       cell_done;

    // Line length and line count depend on what is being drawn
    assign col_last = (scan.phase == phase_title) ? 5'(title_len - 1) : 5'(reg_line_len - 1);
    assign row_last = (scan.phase == phase_title) ? 3'd0 : 3'(num_regs - 1);

    assign glyph_done    = (scan.glyph_col == glyph_last) && (scan.glyph_row == glyph_last);
    assign cell_done     = glyph_done && (scan.cell_col == col_last);
    assign scan.scan_end = cell_done && (scan.cell_row == row_last);

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            scan.glyph_col <= '0;
            scan.glyph_row <= '0;
            scan.cell_col  <= '0;
            scan.cell_row  <= '0;
        end else if (scan.scan_end) begin
            // Next phase starts from the top left cell
            scan.glyph_col <= '0;
            scan.glyph_row <= '0;
            scan.cell_col  <= '0;
            scan.cell_row  <= '0;
        end else if (scan.glyph_col != glyph_last) begin
            scan.glyph_col <= scan.glyph_col + 3'd1;
        end else begin
            scan.glyph_col <= '0;
            if (scan.glyph_row != glyph_last) begin
                scan.glyph_row <= scan.glyph_row + 3'd1;
            end else begin
                scan.glyph_row <= '0;
                if (scan.cell_col != col_last) begin
                    scan.cell_col <= scan.cell_col + 5'd1;
                end else begin
                    scan.cell_col <= '0;
                    scan.cell_row <= scan.cell_row + 3'd1;  // Never passes row_last
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/glyph_scan_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scan position bundle shared by sequencer, counter and data path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface glyph_scan_if
    import text_display_pkg::*;
();

    draw_phase_t phase;
    logic [2:0]  glyph_col;  // Pixel inside the glyph, fastest
    logic [2:0]  glyph_row;
    logic [4:0]  cell_col;   // Character position on the line
    logic [2:0]  cell_row;   // Register line
    logic        scan_end;   // Last pixel of the phase

    modport sequencer (output phase, input scan_end);
    modport counter (input phase, output glyph_col, glyph_row, cell_col, cell_row, scan_end);
    modport consumer (input phase, glyph_col, glyph_row, cell_col, cell_row, scan_end);

endinterface

`default_nettype wire

// ==== logic/pixel_renderer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel renderer: screen position and font colour, registered
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pixel_renderer
    import text_display_pkg::*;
#(
    parameter int text_x0   = 10,
    parameter int title_y0  = 10,
    parameter int regs_y0   = 25,
    parameter int row_pitch = 15
) (
    input  logic                   clock,
    input  logic                   resetn,
    glyph_scan_if.consumer         scan,
    input  glyph_code_t            glyph_code,
    output logic [x_width-1:0]     pixel_x,
    output logic [y_width-1:0]     pixel_y,
    output logic [color_width-1:0] pixel_color,
    output logic                   plot
);

    logic [x_width-1:0] next_x;
    logic [y_width-1:0] line_y0;
    logic [y_width-1:0] next_y;
    logic [7:0]         font_row;
    logic               pixel_on;

    assign next_x = x_width'(text_x0)
                  + x_width'(scan.cell_col) * x_width'(cell_pitch)
                  + x_width'(scan.glyph_col);

    // Top of the current text line
    assign line_y0 = (scan.phase == phase_title) ? y_width'(title_y0)
                   : y_width'(regs_y0) + y_width'(scan.cell_row) * y_width'(row_pitch);
    assign next_y  = line_y0 + y_width'(scan.glyph_row);

    assign font_row = glyph_row_bits(glyph_code, scan.glyph_row);
    assign pixel_on = font_row[~scan.glyph_col];  // Column 0 is bit 7

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            pixel_x     <= '0;
            pixel_y     <= '0;
            pixel_color <= color_off;
            plot        <= 1'b0;
        end else begin
            pixel_x     <= next_x;
            pixel_y     <= next_y;
            pixel_color <= pixel_on ? color_on : color_off;
            plot        <= 1'b1;  // One write every cycle once running
        end
    end

endmodule

`default_nettype wire

// ==== logic/reg_display_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file text overlay, drives a frame buffer write port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module reg_display_top
    import text_display_pkg::*;
#(
    parameter int num_regs  = 8,
    parameter int text_x0   = 10,
    parameter int title_y0  = 10,
    parameter int regs_y0   = 25,
    parameter int row_pitch = 15   // Line spacing of register rows
) (
    input  logic                                clock,
    input  logic                                resetn,
    input  logic [num_regs-1:0][reg_width-1:0] reg_words,
    output logic [x_width-1:0]                  pixel_x,
    output logic [y_width-1:0]                  pixel_y,
    output logic [color_width-1:0]              pixel_color,
    output logic                                plot
);

    glyph_code_t glyph_code;

    glyph_scan_if scan ();

    draw_sequencer u_sequencer (
        .clock  (clock),
        .resetn (resetn),
        .scan   (scan.sequencer)
    );

    glyph_scan_counter #(.num_regs(num_regs)) u_counter (
        .clock  (clock),
        .resetn (resetn),
        .scan   (scan.counter)
    );

    text_source #(.num_regs(num_regs)) u_text (
        .scan       (scan.consumer),
        .reg_words  (reg_words),
        .glyph_code (glyph_code)
    );

    pixel_renderer #(
        .text_x0   (text_x0),
        .title_y0  (title_y0),
        .regs_y0   (regs_y0),
        .row_pitch (row_pitch)
    ) u_renderer (
        .clock       (clock),
        .resetn      (resetn),
        .scan        (scan.consumer),
        .glyph_code  (glyph_code),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_color (pixel_color),
        .plot        (plot)
    );

endmodule

`default_nettype wire

// ==== logic/text_display_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Text overlay package: geometry, glyph codes, draw phase type
// and the 8x8 font row lookup shared by RTL and model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package text_display_pkg;

    typedef logic [5:0] glyph_code_t;  // 0..15 hex digits, rest letters

    typedef enum logic {
        phase_title = 1'b0,
        phase_regs  = 1'b1
    } draw_phase_t;

    localparam int glyph_size   = 8;
    localparam int cell_pitch   = 9;   // 8 pixels plus one blank column
    localparam int title_len    = 17;
    localparam int reg_line_len = 12;
    localparam int hex_digits   = 8;   // Data part of a register line
    localparam int color_width  = 9;
    localparam int x_width      = 10;
    localparam int y_width      = 9;
    localparam int reg_width    = 32;

    localparam logic [color_width-1:0] color_on  = '1;
    localparam logic [color_width-1:0] color_off = '0;

    localparam glyph_code_t code_g     = 6'd16;
    localparam glyph_code_t code_i     = 6'd18;
    localparam glyph_code_t code_l     = 6'd21;
    localparam glyph_code_t code_n     = 6'd23;
    localparam glyph_code_t code_r     = 6'd27;
    localparam glyph_code_t code_s     = 6'd28;
    localparam glyph_code_t code_t     = 6'd29;
    localparam glyph_code_t code_colon = 6'd36;
    localparam glyph_code_t code_space = 6'd37;

    // One byte per row, top row in the upper byte, leftmost pixel in bit 7
    function automatic logic [7:0] glyph_row_bits(input glyph_code_t code,
                                                  input logic [2:0] row);
        logic [63:0] bits;
        case (code)
            6'd0:       bits = 64'h00_7C_86_8A_92_A2_C2_7C;
            6'd1:       bits = 64'h00_70_50_10_10_10_10_FE;
            6'd2:       bits = 64'h00_78_84_04_08_10_20_7C;
            6'd3:       bits = 64'h00_FC_02_02_3C_02_02_FC;
            6'd4:       bits = 64'h00_88_88_88_FE_08_08_08;
            6'd5:       bits = 64'h00_FE_80_80_FC_02_02_FC;
            6'd6:       bits = 64'h00_7C_80_80_FC_82_82_7C;
            6'd7:       bits = 64'h00_FE_02_04_08_10_20_40;
            6'd8:       bits = 64'h00_7C_82_82_7C_82_82_7C;
            6'd9:       bits = 64'h00_7C_82_82_7E_02_02_02;
            6'd10:      bits = 64'h00_78_84_84_FC_84_84_84;  // A
            6'd11:      bits = 64'h00_F0_88_88_F8_84_84_F8;  // B
            6'd12:      bits = 64'h00_7E_80_80_80_80_80_7E;  // C
            6'd13:      bits = 64'h00_F8_84_84_84_84_84_F8;  // D
            6'd14:      bits = 64'h00_FE_80_80_FC_80_80_FE;  // E
            6'd15:      bits = 64'h00_FE_80_80_FC_80_80_80;  // F
            code_g:     bits = 64'h00_7C_82_80_8E_82_82_7C;
            code_i:     bits = 64'h00_7C_10_10_10_10_10_7C;
            code_l:     bits = 64'h00_80_80_80_80_80_80_FC;
            code_n:     bits = 64'h00_82_C2_A2_92_8A_86_82;
            code_r:     bits = 64'h00_F8_84_84_F8_90_88_84;
            code_s:     bits = 64'h00_7C_80_7C_04_04_84_78;
            code_t:     bits = 64'h00_FE_20_20_20_20_20_20;
            code_colon: bits = 64'h00_60_60_00_00_60_60_00;
            default:    bits = 64'h0;                        // Space and unknown codes
        endcase
        return bits[{~row, 3'b000} +: 8];  // Row 0 sits at bits 63:56
    endfunction

endpackage

`default_nettype wire

// ==== logic/text_source.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Glyph code of the current cell, from the title text
// or from the register line "Rn: hhhhhhhh"
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module text_source
    import text_display_pkg::*;
#(
    parameter int num_regs = 8
) (
    glyph_scan_if.consumer                      scan,
    input  logic [num_regs-1:0][reg_width-1:0] reg_words,
    output glyph_code_t                         glyph_code
);

    localparam glyph_code_t code_a = 6'd10;  // Letters shared with hex digits
    localparam glyph_code_t code_e = 6'd14;

    // GENERAL REGISTERS
    localparam glyph_code_t title_text [title_len] = '{
        code_g, code_e, code_n, code_e, code_r, code_a, code_l, code_space,
        code_r, code_e, code_g, code_i, code_s, code_t, code_e, code_r, code_s
    };

    localparam logic [4:0] first_digit = 5'(reg_line_len - hex_digits);

    logic [reg_width-1:0] word;
    logic [2:0]           digit_pos;   // 0 is the leftmost hex digit
    logic [2:0]           nibble_idx;
    logic [3:0]           nibble;

    assign word       = reg_words[scan.cell_row];
    assign digit_pos  = 3'(scan.cell_col - first_digit);
    assign nibble_idx = 3'(hex_digits - 1) - digit_pos;  // MSB nibble first
    assign nibble     = word[{nibble_idx, 2'b00} +: 4];

    always_comb begin
        if (scan.phase == phase_title) begin
            if (scan.cell_col < 5'(title_len)) begin
                glyph_code = title_text[scan.cell_col];
            end else begin
                glyph_code = code_space;
            end
        end else begin
            case (scan.cell_col)
                5'd0:    glyph_code = code_r;
                5'd1:    glyph_code = {3'b000, scan.cell_row};  // Register number digit
                5'd2:    glyph_code = code_colon;
                5'd3:    glyph_code = code_space;
                default: glyph_code = {2'b00, nibble};
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module reg_display_tb \
    -f src.f -o reg_display_sim \
    && ./obj_dir/reg_display_sim | tee /dev/stderr | grep "Regression passed" > /dev/null \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

// ==== src.f ====
logic/text_display_pkg.sv
logic/glyph_scan_if.sv
logic/draw_sequencer.sv
logic/glyph_scan_counter.sv
logic/text_source.sv
logic/pixel_renderer.sv
logic/reg_display_top.sv
bench/reg_display_assert.sv
bench/reg_display_tb.sv
